// File: hw/sd_share_pkg.sv
/*
 * SD card sharing: common constants
 * controller count, request filter depth, card idle levels
 * and the controller index map in priority order
 */
`default_nettype none

package sd_share_pkg;

   //**************************************************
   // sizing
   //**************************************************
   localparam int SD_CTRL_COUNT     = 6;     // disk controllers on one card
   localparam int SDREQ_SYNC_STAGES = 2;     // flops per request line

   //**************************************************
   // card levels with no owner
   //**************************************************
   localparam logic SD_IDLE_CS   = 1'b1;     // card deselected
   localparam logic SD_IDLE_MOSI = 1'b1;     // data line high
   localparam logic SD_IDLE_SCLK = 1'b0;     // clock parked low

   // controller indices, 0 wins
   localparam int CTRL_RK = 0;               // RK11
   localparam int CTRL_DW = 1;               // DW hard disk
   localparam int CTRL_DM = 2;               // RK611
   localparam int CTRL_DB = 3;               // RH70
   localparam int CTRL_DX = 4;               // RX01
   localparam int CTRL_MY = 5;               // MY floppy

endpackage

`default_nettype wire

// File: hw/sd_req_sync.sv
/*
 * SD request filter
 * each controller request goes through a short flop chain on sdclock,
 * activity LEDs follow the raw request, active low
 */
`timescale 1ns/1ns
`default_nettype none

module sd_req_sync #(
   parameter int N_CTRL = 6                      // number of controllers
) (
   input  wire logic              sdclock,       // card clock domain
   input  wire logic              rst_n_i,       // async reset, low active
   input  wire logic [N_CTRL-1:0] sd_req_i,      // raw request levels
   output logic      [N_CTRL-1:0] req_filt_o,    // filtered requests
   output logic      [N_CTRL-1:0] act_led_n_o    // activity LEDs, low = busy
);

   import sd_share_pkg::*;

   //**************************************************
   // request flop chain
   //**************************************************
   logic [SDREQ_SYNC_STAGES-1:0][N_CTRL-1:0] stage_q;   // stage 0 samples the pins

   always_ff @(posedge sdclock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage_q <= '0;                          // no requests seen
      end else begin
         stage_q[0] <= sd_req_i;                 // first capture
         for (int s = 1; s < SDREQ_SYNC_STAGES; s++) begin
            stage_q[s] <= stage_q[s-1];          // shift toward the output
         end
      end
   end

   assign req_filt_o = stage_q[SDREQ_SYNC_STAGES-1];   // last stage feeds dispatcher

   //**************************************************
   // activity LEDs
   //**************************************************
   // driven straight from the pins so a short request still blinks
   assign act_led_n_o = ~sd_req_i;

endmodule

`default_nettype wire

// File: hw/sd_dispatcher.sv
/*
 * SD card dispatcher
 * fixed priority grant, index 0 highest,
 * a grant is held until its owner drops the filtered request
 */
`timescale 1ns/1ns
`default_nettype none

module sd_dispatcher #(
   parameter int N_CTRL = 6                      // number of controllers
) (
   input  wire logic              sdclock,       // card clock domain
   input  wire logic              rst_n_i,       // async reset, low active
   input  wire logic [N_CTRL-1:0] req_filt_i,    // filtered requests
   output logic      [N_CTRL-1:0] gnt_o          // one-hot or zero grant
);

   logic [N_CTRL-1:0] gnt_q;                     // grant register
   logic [N_CTRL-1:0] gnt_d;                     // next grant
   logic              busy;                      // someone owns the card
   logic              owner_req;                 // owner still asking
   logic              pick_found;                // search hit marker

   assign busy      = |gnt_q;
   assign owner_req = |(gnt_q & req_filt_i);     // only the owner's bit counts

   //**************************************************
   // next grant
   //**************************************************
   always_comb begin
      gnt_d      = gnt_q;                        // hold by default
      pick_found = 1'b0;
      if (!busy) begin
         // idle, search upward for the first request
         for (int i = 0; i < N_CTRL; i++) begin
            if (req_filt_i[i] && !pick_found) begin
               gnt_d[i]   = 1'b1;                // lowest index wins
               pick_found = 1'b1;
            end
         end
      end else if (!owner_req) begin
         gnt_d = '0;                             // owner let go, card free
      end
      // higher priority requests wait here, no preemption
   end

   always_ff @(posedge sdclock or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_q <= '0;                            // nobody owns the card
      end else begin
         gnt_q <= gnt_d;
      end
   end

   assign gnt_o = gnt_q;

   //**************************************************
   // grant checks
   //**************************************************
   a_gnt_onehot0: assert property (
      @(posedge sdclock) disable iff (!rst_n_i)
      $onehot0(gnt_q))
      else $error("sd_dispatcher: more than one grant active");

   for (genvar g = 0; g < N_CTRL; g++) begin : g_gnt_chk
      // a grant appears only from idle and for a live request
      a_gnt_rise: assert property (
         @(posedge sdclock) disable iff (!rst_n_i)
         $rose(gnt_q[g]) |-> ($past(req_filt_i[g]) && ($past(gnt_q) == '0)))
         else $error("sd_dispatcher: grant %0d rose without request or while busy", g);

      // a grant goes away only after its request fell
      a_gnt_fall: assert property (
         @(posedge sdclock) disable iff (!rst_n_i)
         $fell(gnt_q[g]) |-> !$past(req_filt_i[g]))
         else $error("sd_dispatcher: grant %0d dropped while still requested", g);
   end

endmodule

`default_nettype wire

// File: hw/sd_line_mux.sv
/*
 * SD card line multiplexer
 * routes cs, mosi and sclk of the granted controller to the card,
 * idle levels when no grant is active
 */
`timescale 1ns/1ns
`default_nettype none

module sd_line_mux #(
   parameter int N_CTRL = 6                      // number of controllers
) (
   input  wire logic [N_CTRL-1:0] gnt_i,         // one-hot or zero grant
   input  wire logic [N_CTRL-1:0] ctrl_cs_i,     // per controller chip select
   input  wire logic [N_CTRL-1:0] ctrl_mosi_i,   // per controller data out
   input  wire logic [N_CTRL-1:0] ctrl_sclk_i,   // per controller spi clock
   output logic                   sdcard_cs_o,   // to card
   output logic                   sdcard_mosi_o,
   output logic                   sdcard_sclk_o
);

   import sd_share_pkg::*;

   //**************************************************
   // line select
   //**************************************************
   always_comb begin
      sdcard_cs_o   = SD_IDLE_CS;                // card deselected between owners
      sdcard_mosi_o = SD_IDLE_MOSI;
      sdcard_sclk_o = SD_IDLE_SCLK;
      for (int i = 0; i < N_CTRL; i++) begin
         if (gnt_i[i]) begin
            sdcard_cs_o   = ctrl_cs_i[i];        // owner drives the card
            sdcard_mosi_o = ctrl_mosi_i[i];
            sdcard_sclk_o = ctrl_sclk_i[i];
         end
      end
   end

   // two owners at once would short two controllers onto the card
   always_comb begin
      a_gnt_onehot0: assert ($onehot0(gnt_i))
         else $error("sd_line_mux: grant input not one-hot");
   end

endmodule

`default_nettype wire

// File: hw/sd_share_top.sv
/*
 * SD card sharing top level
 * request filter, priority dispatcher and card line multiplexer
 * for several disk controllers on one SD card
 */
`timescale 1ns/1ns
`default_nettype none

module sd_share_top #(
   parameter int N_CTRL = sd_share_pkg::SD_CTRL_COUNT   // controllers on the card
) (
   input  wire logic              sdclock,       // card clock
   input  wire logic              rst_n_i,       // async reset, low active

   // controller side, bit order RK DW DM DB DX MY from bit 0
   input  wire logic [N_CTRL-1:0] sd_req_i,      // access requests
   input  wire logic [N_CTRL-1:0] ctrl_cs_i,     // chip selects
   input  wire logic [N_CTRL-1:0] ctrl_mosi_i,   // data toward card
   input  wire logic [N_CTRL-1:0] ctrl_sclk_i,   // spi clocks
   output logic      [N_CTRL-1:0] sd_gnt_o,      // access grants
   output logic      [N_CTRL-1:0] act_led_n_o,   // activity LEDs

   // card side
   output logic                   sdcard_cs_o,
   output logic                   sdcard_mosi_o,
   output logic                   sdcard_sclk_o
);

   logic [N_CTRL-1:0] req_filt;                  // requests after the filter
   logic [N_CTRL-1:0] gnt;                       // current owner, one-hot or zero

   //**************************************************
   // request filter
   //**************************************************
   sd_req_sync #(
      .N_CTRL      (N_CTRL)
   ) sd_req_sync_inst (
      .sdclock     (sdclock),
      .rst_n_i     (rst_n_i),
      .sd_req_i    (sd_req_i),
      .req_filt_o  (req_filt),
      .act_led_n_o (act_led_n_o)
   );

   //**************************************************
   // dispatcher
   //**************************************************
   sd_dispatcher #(
      .N_CTRL     (N_CTRL)
   ) sd_dispatcher_inst (
      .sdclock    (sdclock),
      .rst_n_i    (rst_n_i),
      .req_filt_i (req_filt),
      .gnt_o      (gnt)
   );

   //**************************************************
   // card line multiplexer
   //**************************************************
   sd_line_mux #(
      .N_CTRL        (N_CTRL)
   ) sd_line_mux_inst (
      .gnt_i         (gnt),
      .ctrl_cs_i     (ctrl_cs_i),
      .ctrl_mosi_i   (ctrl_mosi_i),
      .ctrl_sclk_i   (ctrl_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

   assign sd_gnt_o = gnt;                        // controllers see their grant

endmodule

`default_nettype wire

// File: verif/sd_share_tb.sv
/*
 * SD card sharing testbench
 * directed tests for filter latency, fixed priority grant,
 * no preemption, release to idle and the card line multiplexer
 */
`timescale 1ns/1ns
`default_nettype none

module sd_share_tb;

   import sd_share_pkg::*;

   localparam int N               = SD_CTRL_COUNT;          // controllers on the card
   localparam int CLK_PERIOD      = 4;                      // ns
   localparam int RST_CYCLES      = 16;
   localparam int GNT_EDGES       = SDREQ_SYNC_STAGES + 1;  // drive to grant, filter + grant flop
   localparam int TEST_CYCLES     = 500;                    // rough sum of all test lengths
   localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;        // generous margin

   logic         sdclock;
   logic         rst_n;
   logic [N-1:0] sd_req;
   logic [N-1:0] ctrl_cs;
   logic [N-1:0] ctrl_mosi;
   logic [N-1:0] ctrl_sclk;
   logic [N-1:0] sd_gnt;
   logic [N-1:0] act_led_n;
   logic         sdcard_cs;
   logic         sdcard_mosi;
   logic         sdcard_sclk;

   int           check_count;
   int           error_count;
   logic [31:0]  rng_state;                                 // lcg state

   sd_share_top #(
      .N_CTRL        (SD_CTRL_COUNT)
   ) sd_share_top_inst (
      .sdclock       (sdclock),
      .rst_n_i       (rst_n),
      .sd_req_i      (sd_req),
      .ctrl_cs_i     (ctrl_cs),
      .ctrl_mosi_i   (ctrl_mosi),
      .ctrl_sclk_i   (ctrl_sclk),
      .sd_gnt_o      (sd_gnt),
      .act_led_n_o   (act_led_n),
      .sdcard_cs_o   (sdcard_cs),
      .sdcard_mosi_o (sdcard_mosi),
      .sdcard_sclk_o (sdcard_sclk)
   );

   initial begin
      sdclock = 1'b0;
      forever #(CLK_PERIOD / 2) sdclock = ~sdclock;         // 250 MHz
   end

   //**************************************************
   // helpers
   //**************************************************
   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // numerical recipes lcg
      return rng_state;
   endfunction

   function automatic logic [N-1:0] onehot(input int idx);
      logic [N-1:0] v;
      v      = '0;
      v[idx] = 1'b1;
      return v;
   endfunction

   task automatic next_cycle();
      @(negedge sdclock);                                   // one rising edge passed
   endtask

   task automatic shuffle_lines();
      ctrl_cs   = N'(lcg_next() >> 5);                      // upper bits mix better
      ctrl_mosi = N'(lcg_next() >> 11);
      ctrl_sclk = N'(lcg_next() >> 17);
   endtask

   task automatic compare_vec(input logic [N-1:0] got, input logic [N-1:0] exp,
                              input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_bit(input logic got, input logic exp, input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // card lines follow the owner, idle levels with owner < 0
   task automatic check_card(input int owner);
      logic exp_cs;
      logic exp_mosi;
      logic exp_sclk;
      #1;                                                   // let the mux settle
      if (owner < 0) begin
         exp_cs   = SD_IDLE_CS;
         exp_mosi = SD_IDLE_MOSI;
         exp_sclk = SD_IDLE_SCLK;
      end else begin
         exp_cs   = ctrl_cs[owner];
         exp_mosi = ctrl_mosi[owner];
         exp_sclk = ctrl_sclk[owner];
      end
      compare_bit(sdcard_cs, exp_cs, $sformatf("card cs, owner %0d", owner));
      compare_bit(sdcard_mosi, exp_mosi, $sformatf("card mosi, owner %0d", owner));
      compare_bit(sdcard_sclk, exp_sclk, $sformatf("card sclk, owner %0d", owner));
      compare_vec(act_led_n, ~sd_req, "activity LEDs");   // raw inverse, no delay
   endtask

   // grant must stay at hold until the last edge, then equal final_gnt
   task automatic wait_grant(input logic [N-1:0] hold, input logic [N-1:0] final_gnt,
                             input int edges, input string what);
      for (int e = 1; e <= edges; e++) begin
         next_cycle();
         if (e < edges) compare_vec(sd_gnt, hold, {what, ", too early"});
         else compare_vec(sd_gnt, final_gnt, what);
      end
   endtask

   task automatic hold_owner(input int owner, input int cycles);
      repeat (cycles) begin
         next_cycle();
         shuffle_lines();
         compare_vec(sd_gnt, onehot(owner), $sformatf("grant held by %0d", owner));
         check_card(owner);
      end
   endtask

   task automatic request_alone(input int idx);
      next_cycle();
      sd_req[idx] = 1'b1;
      wait_grant('0, onehot(idx), GNT_EDGES, $sformatf("grant to %0d", idx));
   endtask

   task automatic release_owner(input int idx);
      next_cycle();
      sd_req[idx] = 1'b0;
      wait_grant(onehot(idx), '0, GNT_EDGES, $sformatf("release of %0d", idx));
      check_card(-1);
   endtask

   // lines keep moving through the release, card follows the owner up to the clear
   task automatic release_tracked(input int idx);
      next_cycle();
      sd_req[idx] = 1'b0;
      for (int e = 1; e <= GNT_EDGES; e++) begin
         next_cycle();
         shuffle_lines();
         if (e < GNT_EDGES) begin
            compare_vec(sd_gnt, onehot(idx),
                        $sformatf("grant %0d before release latency", idx));
            check_card(idx);                                // still owns the card
         end else begin
            compare_vec(sd_gnt, '0, $sformatf("grant cleared after release of %0d", idx));
            check_card(-1);                                 // idle in the same cycle
         end
      end
   endtask

   //**************************************************
   // tests
   //**************************************************
   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (RST_CYCLES - 1) begin
         next_cycle();
         sd_req = N'(lcg_next() >> 9);                      // LEDs live even in reset
         #1 compare_vec(act_led_n, ~sd_req, "activity LEDs in reset");
      end
      next_cycle();                                         // last reset edge
      sd_req = '0;
      rst_n  = 1'b1;
   endtask

   task automatic test_reset();
      compare_vec(sd_gnt, '0, "grant after reset");
      repeat (10) begin
         next_cycle();
         shuffle_lines();                                   // card must ignore these
         compare_vec(sd_gnt, '0, "grant idle after reset");
         check_card(-1);
      end
   endtask

   task automatic test_single_request();
      request_alone(CTRL_DX);
      hold_owner(CTRL_DX, 20);
      compare_bit(act_led_n[CTRL_DX], 1'b0, "DX LED while granted");
      release_owner(CTRL_DX);
   endtask

   task automatic test_priority();
      next_cycle();
      sd_req[CTRL_MY] = 1'b1;                              // same edge, DW wins
      sd_req[CTRL_DW] = 1'b1;
      wait_grant('0, onehot(CTRL_DW), GNT_EDGES, "priority grant to DW");
      hold_owner(CTRL_DW, 5);
      release_owner(CTRL_DW);
      wait_grant('0, onehot(CTRL_MY), 1, "waiting MY granted");   // next edge after clear
      hold_owner(CTRL_MY, 5);
      release_owner(CTRL_MY);
   endtask

   task automatic test_no_preemption();
      request_alone(CTRL_DB);
      next_cycle();
      sd_req[CTRL_RK] = 1'b1;                              // higher priority arrives late
      hold_owner(CTRL_DB, 30);
      release_owner(CTRL_DB);
      wait_grant('0, onehot(CTRL_RK), 1, "RK granted after DB");
      hold_owner(CTRL_RK, 3);
      release_owner(CTRL_RK);
   endtask

   task automatic test_release_to_idle();
      request_alone(CTRL_DM);
      hold_owner(CTRL_DM, 5);
      release_tracked(CTRL_DM);
   endtask

   task automatic test_mux_sweep();
      for (int i = 0; i < N; i++) begin
         request_alone(i);
         check_card(i);                                     // first cycle of the grant
         hold_owner(i, 12);
         release_tracked(i);
      end
   endtask

   //**************************************************
   // main sequence and watchdog
   //**************************************************
   initial begin
      rst_n       = 1'b0;
      sd_req      = '0;
      ctrl_cs     = '0;
      ctrl_mosi   = '0;
      ctrl_sclk   = '0;
      check_count = 0;
      error_count = 0;
      rng_state   = 32'hbf4b_40c2;
      apply_reset();
      test_reset();
      test_single_request();
      test_priority();
      test_no_preemption();
      test_release_to_idle();
      test_mux_sweep();
      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0) $display("TESTBENCH PASSED");
      else $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
hw/sd_share_pkg.sv
hw/sd_req_sync.sv
hw/sd_dispatcher.sv
hw/sd_line_mux.sv
hw/sd_share_top.sv
verif/sd_share_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the SD share testbench with Verilator and runs it
# exit status is zero only when the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module sd_share_tb -f build.f -o sd_share_sim \
   && ./obj_dir/sd_share_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }
